// ==== sources.f ====
hdl/ppu_pkg.sv
hdl/ppu_cfg_ctrl.sv
hdl/n64_vdemux.sv
hdl/n64_vinfo.sv
hdl/ppu_top.sv
testbench/tb_clkgen.sv
testbench/tb_ppu_top.sv

// ==== Makefile ====
# Verilator build for the N64 video input PPU testbench

VERILATOR ?= verilator
TOP       ?= tb_ppu_top
RTL_TOP   ?= ppu_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_ppu_top.sv ====
// testbench for ppu_top; drives pixels, fields and config words and checks them with assertions
module tb_ppu_top;

  import ppu_pkg::*;

  // 2 bus cycles per line over all fields, plus pixels and config traffic
  localparam int FIELD_LINES = 263 + 262 + 313 + 313;
  localparam int TEST_CYCLES = 2 * FIELD_LINES + 20 + 600;
  localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

  logic       clk;
  logic       rst_n;
  logic       nVDSYNC_i;
  color_i_t   VD_i;
  logic       cfg_req_i;
  ppu_cfg_t   cfg_i;
  logic       cfg_ack_o;
  ppu_state_t state_o;
  logic       vclk_sel_o;
  pixel_t     pix_o;
  logic       pix_valid_o;

  int          err_value;
  int          err_other;
  int          cycles;
  int          pix_count;
  logic [31:0] rng_state;
  ppu_cfg_t    cur_cfg;
  color_i_t    vd_h1;
  color_i_t    vd_h2;
  color_i_t    vd_h3;
  color_i_t    vd_h4;
  pixel_t      exp_pix;

  tb_clkgen clkgen_i (.clk_o(clk), .rst_n_o(rst_n));

  ppu_top dut_i (
    .N64_CLK_i   (clk),
    .rst_n_i     (rst_n),
    .nVDSYNC_i   (nVDSYNC_i),
    .VD_i        (VD_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_i       (cfg_i),
    .cfg_ack_o   (cfg_ack_o),
    .state_o     (state_o),
    .vclk_sel_o  (vclk_sel_o),
    .pix_o       (pix_o),
    .pix_valid_o (pix_valid_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 7-bit sample widened by repeating its top bit, then masked to 5:6:5 in 16-bit mode
  function automatic color_o_t widen_color(input color_i_t c, input logic c16,
                                           input logic is_green);
    color_o_t mask;
    mask = 8'hff;
    if (c16) begin
      mask = is_green ? 8'hfc : 8'hf8;
    end
    return {c, c[6]} & mask;
  endfunction

  function automatic ppu_cfg_t make_cfg(input target_res_e res, input logic vga,
                                        input logic f60, input logic f50,
                                        input logic llm, input logic c16);
    ppu_cfg_t c;
    c.target_res   = res;
    c.use_vga_480p = vga;
    c.force60      = f60;
    c.force50      = f50;
    c.low_latency  = llm;
    c.color16      = c16;
    return c;
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] got_v);
    err_value++;
    $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp_v, got_v);
  endtask

  task automatic report_other(input string what);
    err_other++;
    $display("error at time %0t: %s", $time, what);
  endtask

  // ==================================================
  // bus history and expected pixel
  // ==================================================
  always @(posedge clk) begin
    vd_h1 <= VD_i;
    vd_h2 <= vd_h1;
    vd_h3 <= vd_h2;
    vd_h4 <= vd_h3;
    if (rst_n && pix_valid_o) begin
      pix_count++;
    end
  end

  assign exp_pix = {vd_h4[3:0], widen_color(vd_h3, cur_cfg.color16, 1'b0),
                    widen_color(vd_h2, cur_cfg.color16, 1'b1),
                    widen_color(vd_h1, cur_cfg.color16, 1'b0)};

  a_pix_value : assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid_o |-> (pix_o == exp_pix))
    else report_value("pix_o", 32'($sampled(exp_pix)), 32'($sampled(pix_o)));

  // full sync, red, green, blue group gives a pixel on the next cycle
  a_pix_timing : assert property (@(posedge clk) disable iff (!rst_n)
    (!$past(nVDSYNC_i, 3) && $past(nVDSYNC_i, 2) && $past(nVDSYNC_i, 1) && nVDSYNC_i)
    |=> pix_valid_o)
    else report_other("pix_valid_o missing four cycles after a sync phase");

  a_pix_spurious : assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid_o |-> (!$past(nVDSYNC_i, 4) && $past(nVDSYNC_i, 3) &&
                     $past(nVDSYNC_i, 2) && $past(nVDSYNC_i, 1)))
    else report_other("pix_valid_o without a complete pixel on the bus");

  a_ack_rise : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cfg_ack_o) |-> $past(cfg_req_i))
    else report_other("cfg_ack_o rose without cfg_req_i");

  a_ack_fall : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cfg_ack_o) |-> !$past(cfg_req_i))
    else report_other("cfg_ack_o fell while cfg_req_i was still high");

  // ==================================================
  // watchdog
  // ==================================================
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==================================================
  // stimulus tasks
  // ==================================================
  task automatic drive_sync(input sync_t s);
    @(posedge clk);
    nVDSYNC_i <= 1'b0;
    VD_i      <= {3'b000, s};
  endtask

  task automatic drive_data(input color_i_t c);
    @(posedge clk);
    nVDSYNC_i <= 1'b1;
    VD_i      <= c;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      nVDSYNC_i <= 1'b1;
    end
  endtask

  task automatic send_pixel();
    sync_t s;
    rng_state = xorshift32(rng_state);
    // keep nVSYNC and nHSYNC high so pixels neither end a field nor add lines
    s = {1'b1, rng_state[2], 1'b1, rng_state[0]};
    drive_sync(s);
    drive_data(rng_state[14:8]);
    drive_data(rng_state[21:15]);
    drive_data(rng_state[28:22]);
    idle(2);
  endtask

  // n lines, each an nHSYNC high then low sample, then the vsync field end
  task automatic gen_field(input int n);
    for (int i = 0; i < n; i++) begin
      drive_sync(4'b1111);
      drive_sync(4'b1100);
    end
    drive_sync(4'b0111);
    drive_sync(4'b1111);
    idle(4);
  endtask

  task automatic do_config(input ppu_cfg_t c);
    @(posedge clk);
    cfg_i     <= c;
    cfg_req_i <= 1'b1;
    while (!cfg_ack_o) @(posedge clk);
    cfg_req_i <= 1'b0;
    @(posedge clk);
    while (cfg_ack_o) @(posedge clk);
    cur_cfg = c;
    idle(3);
  endtask

  task automatic check_state(input vinfo_t ev);
    logic llm_e;
    logic hz_e;
    logic vclk_e;
    llm_e = cur_cfg.low_latency || (cur_cfg.target_res == RES_240P);
    if (llm_e) begin
      hz_e = ev.pal;
    end else if (cur_cfg.force60) begin
      hz_e = 1'b0;
    end else if (cur_cfg.force50) begin
      hz_e = 1'b1;
    end else begin
      hz_e = ev.pal;
    end
    if (llm_e) begin
      vclk_e = ev.n64_480i;
    end else if (cur_cfg.target_res inside {RES_1440P, RES_1080P, RES_720P}) begin
      vclk_e = 1'b0;
    end else if (cur_cfg.target_res == RES_480P) begin
      vclk_e = !cur_cfg.use_vga_480p;
    end else begin
      vclk_e = 1'b1;
    end
    assert (state_o.vinfo == ev)
      else report_value("state_o.vinfo", 32'(ev), 32'(state_o.vinfo));
    assert (state_o.vmode.target_res == cur_cfg.target_res)
      else report_value("state_o.vmode.target_res", 32'(cur_cfg.target_res),
                        32'(state_o.vmode.target_res));
    assert (state_o.vmode.is_50hz == hz_e)
      else report_value("state_o.vmode.is_50hz", 32'(hz_e), 32'(state_o.vmode.is_50hz));
    assert (state_o.llm == llm_e)
      else report_value("state_o.llm", 32'(llm_e), 32'(state_o.llm));
    assert (state_o.color16 == cur_cfg.color16)
      else report_value("state_o.color16", 32'(cur_cfg.color16), 32'(state_o.color16));
    assert (vclk_sel_o == vclk_e)
      else report_value("vclk_sel_o", 32'(vclk_e), 32'(vclk_sel_o));
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    nVDSYNC_i = 1'b1;
    VD_i      = '0;
    cfg_req_i = 1'b0;
    cfg_i     = '0;
    cur_cfg   = '0;
    err_value = 0;
    err_other = 0;
    cycles    = 0;
    pix_count = 0;
    rng_state = 32'hee73e332;

    @(posedge rst_n);
    idle(3);
    assert (!cfg_ack_o) else report_value("cfg_ack_o", 32'd0, 32'(cfg_ack_o));
    check_state(3'b000);

    repeat (6) send_pixel();
    do_config(make_cfg(RES_960P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    check_state(3'b000);
    repeat (6) send_pixel();

    // NTSC interlaced, then PAL progressive
    do_config('0);
    gen_field(263);
    gen_field(262);
    check_state(3'b101);
    gen_field(313);
    gen_field(313);
    check_state(3'b110);

    do_config(make_cfg(RES_960P, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    check_state(3'b110);
    do_config(make_cfg(RES_240P, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    check_state(3'b110);
    do_config(make_cfg(RES_1080P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    check_state(3'b110);
    do_config(make_cfg(RES_480P, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    check_state(3'b110);
    do_config(make_cfg(RES_480P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    check_state(3'b110);

    idle(4);
    if (pix_count < 12) begin
      report_other("fewer pixels came out than were sent");
    end
    $display("errors: value=%0d other=%0d pixels=%0d", err_value, err_other, pix_count);
    if (err_value == 0 && err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clkgen.sv ====
// testbench clock and reset source; 100 unit clock period, reset held low for 8 cycles
module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== hdl/ppu_top.sv ====
// top level of the N64 video input PPU; connects the config controller, demux and vinfo
module ppu_top (
  input  logic                N64_CLK_i,
  input  logic                rst_n_i,
  input  logic                nVDSYNC_i,
  input  ppu_pkg::color_i_t   VD_i,
  input  logic                cfg_req_i,
  input  ppu_pkg::ppu_cfg_t   cfg_i,
  output logic                cfg_ack_o,
  output ppu_pkg::ppu_state_t state_o,
  output logic                vclk_sel_o,
  output ppu_pkg::pixel_t     pix_o,
  output logic                pix_valid_o
);

  import ppu_pkg::*;

  logic   color16;
  sync_t  sync;
  logic   sync_valid;
  vinfo_t vinfo;

  ppu_cfg_ctrl cfg_ctrl_i (
    .N64_CLK_i  (N64_CLK_i),
    .rst_n_i    (rst_n_i),
    .cfg_req_i  (cfg_req_i),
    .cfg_i      (cfg_i),
    .cfg_ack_o  (cfg_ack_o),
    .vinfo_i    (vinfo),
    .color16_o  (color16),
    .vclk_sel_o (vclk_sel_o),
    .state_o    (state_o)
  );

  n64_vdemux vdemux_i (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .nVDSYNC_i    (nVDSYNC_i),
    .VD_i         (VD_i),
    .color16_i    (color16),
    .sync_o       (sync),
    .sync_valid_o (sync_valid),
    .pix_o        (pix_o),
    .pix_valid_o  (pix_valid_o)
  );

  n64_vinfo vinfo_i (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .sync_i       (sync),
    .sync_valid_i (sync_valid),
    .vinfo_o      (vinfo)
  );

endmodule

// ==== hdl/n64_vinfo.sv ====
// counts lines per field from the sampled sync bits and derives detected, PAL and 480i flags
module n64_vinfo (
  input  logic            N64_CLK_i,
  input  logic            rst_n_i,
  input  ppu_pkg::sync_t  sync_i,
  input  logic            sync_valid_i,
  output ppu_pkg::vinfo_t vinfo_o
);

  import ppu_pkg::*;

  logic      vsync_prev;
  logic      hsync_prev;
  line_cnt_t line_cnt;
  logic      prev_parity;
  logic      good_prev;

  logic      field_end;
  logic      hsync_fall;
  line_cnt_t cnt_now;
  logic      field_ok;

  assign field_end  = sync_valid_i & vsync_prev & ~sync_i[SYNC_NVSYNC_BIT];
  assign hsync_fall = hsync_prev & ~sync_i[SYNC_NHSYNC_BIT];
  assign cnt_now    = line_cnt + line_cnt_t'(hsync_fall);
  assign field_ok   = (cnt_now >= line_cnt_t'(MIN_FIELD_LINES));

  // ==================================================
  // edge history and line counter
  // ==================================================
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vsync_prev <= 1'b1;
      hsync_prev <= 1'b1;
      line_cnt   <= '0;
    end else if (sync_valid_i) begin
      vsync_prev <= sync_i[SYNC_NVSYNC_BIT];
      hsync_prev <= sync_i[SYNC_NHSYNC_BIT];
      if (field_end) begin
        line_cnt <= '0;
      end else begin
        line_cnt <= cnt_now;
      end
    end
  end

  // ==================================================
  // per-field flag update
  // ==================================================
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vinfo_o     <= '0;
      prev_parity <= 1'b0;
      good_prev   <= 1'b0;
    end else if (field_end) begin
      vinfo_o.pal <= (cnt_now > line_cnt_t'(PAL_LINE_THRESHOLD));
      if (field_ok) begin
        // interlaced fields alternate between odd and even line counts
        vinfo_o.n64_480i <= cnt_now[0] ^ prev_parity;
        prev_parity      <= cnt_now[0];
        if (good_prev) begin
          vinfo_o.detected <= 1'b1;
        end
        good_prev <= 1'b1;
      end else begin
        vinfo_o.detected <= 1'b0;
        good_prev        <= 1'b0;
      end
    end
  end

  // a stalled vsync must not let the count roll over silently
  a_line_cnt_no_wrap : assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
    (sync_valid_i && hsync_fall && !field_end) |-> (line_cnt != '1)
  );

endmodule

// ==== hdl/n64_vdemux.sv ====
// splits the multiplexed N64 video bus into sync samples and expanded RGB pixels
module n64_vdemux (
  input  logic              N64_CLK_i,
  input  logic              rst_n_i,
  input  logic              nVDSYNC_i,
  input  ppu_pkg::color_i_t VD_i,
  input  logic              color16_i,
  output ppu_pkg::sync_t    sync_o,
  output logic              sync_valid_o,
  output ppu_pkg::pixel_t   pix_o,
  output logic              pix_valid_o
);

  import ppu_pkg::*;

  demux_phase_e phase;
  color_i_t     red_q;
  color_i_t     green_q;

  // 7 to 8 bit with MSB replicated into the LSB
  // 16-bit mode drops to 5:6:5 precision
  function automatic color_o_t expand_color(input color_i_t c, input logic c16,
                                            input logic is_green);
    color_o_t x;
    x = {c, c[COLOR_W_I-1]};
    if (c16) begin
      if (is_green) begin
        x[1:0] = 2'b00;
      end else begin
        x[2:0] = 3'b000;
      end
    end
    return x;
  endfunction

  // ==================================================
  // phase tracking and control
  // ==================================================
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase        <= PH_SYNC;
      sync_valid_o <= 1'b0;
      pix_valid_o  <= 1'b0;
    end else begin
      sync_valid_o <= 1'b0;
      pix_valid_o  <= 1'b0;
      if (!nVDSYNC_i) begin
        // sync phase restarts the sequence
        phase        <= PH_RED;
        sync_valid_o <= 1'b1;
      end else begin
        case (phase)
          PH_RED:   phase <= PH_GREEN;
          PH_GREEN: phase <= PH_BLUE;
          PH_BLUE: begin
            phase       <= PH_SYNC;
            pix_valid_o <= 1'b1;
          end
          default:  phase <= PH_SYNC;
        endcase
      end
    end
  end

  // ==================================================
  // sample and pixel registers
  // ==================================================
  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      sync_o <= VD_i[SYNC_W-1:0];
    end else begin
      case (phase)
        PH_RED:   red_q   <= VD_i;
        PH_GREEN: green_q <= VD_i;
        PH_BLUE: begin
          pix_o.sync  <= sync_o;
          pix_o.red   <= expand_color(red_q, color16_i, 1'b0);
          pix_o.green <= expand_color(green_q, color16_i, 1'b1);
          pix_o.blue  <= expand_color(VD_i, color16_i, 1'b0);
        end
        default: ;
      endcase
    end
  end

  // one pixel per four bus cycles at most
  a_pix_valid_pulse : assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
    pix_valid_o |=> !pix_valid_o
  );

endmodule

// ==== hdl/ppu_cfg_ctrl.sv ====
// config handshake and output mode decoder; latches the config word and reports the PPU state
module ppu_cfg_ctrl (
  input  logic                 N64_CLK_i,
  input  logic                 rst_n_i,
  input  logic                 cfg_req_i,
  input  ppu_pkg::ppu_cfg_t    cfg_i,
  output logic                 cfg_ack_o,
  input  ppu_pkg::vinfo_t      vinfo_i,
  output logic                 color16_o,
  output logic                 vclk_sel_o,
  output ppu_pkg::ppu_state_t  state_o
);

  import ppu_pkg::*;

  cfg_hs_e  hs_state;
  ppu_cfg_t cfg_q;

  logic direct_mode;
  logic llm;
  logic is_50hz;
  logic vclk_sel;

  // ==================================================
  // four-phase req/ack handshake
  // ==================================================
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hs_state <= HS_IDLE;
      cfg_q    <= '0;
    end else begin
      case (hs_state)
        HS_IDLE: begin
          if (cfg_req_i) begin
            cfg_q    <= cfg_i;
            hs_state <= HS_ACK;
          end
        end
        HS_ACK: begin
          // hold ack until the requester lets go
          if (!cfg_req_i) begin
            hs_state <= HS_IDLE;
          end
        end
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  assign cfg_ack_o = (hs_state == HS_ACK);
  assign color16_o = cfg_q.color16;

  // ==================================================
  // mode decode
  // ==================================================
  assign direct_mode = (cfg_q.target_res == RES_240P);
  // 240p direct output always runs low latency
  assign llm = cfg_q.low_latency | direct_mode;

  always_comb begin
    if (llm) begin
      // no Hz forcing in llm, follow the input
      is_50hz = vinfo_i.pal;
    end else if (cfg_q.force60) begin
      is_50hz = 1'b0;
    end else if (cfg_q.force50) begin
      is_50hz = 1'b1;
    end else begin
      is_50hz = vinfo_i.pal;
    end
  end

  always_comb begin
    if (llm) begin
      vclk_sel = vinfo_i.n64_480i;
    end else begin
      case (cfg_q.target_res)
        RES_1440P, RES_1080P, RES_720P: vclk_sel = 1'b0;
        RES_480P:                       vclk_sel = ~cfg_q.use_vga_480p;
        default:                        vclk_sel = 1'b1;
      endcase
    end
  end

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_o    <= '0;
      vclk_sel_o <= 1'b0;
    end else begin
      state_o.vinfo            <= vinfo_i;
      state_o.vmode.target_res <= cfg_q.target_res;
      state_o.vmode.is_50hz    <= is_50hz;
      state_o.llm              <= llm;
      state_o.color16          <= cfg_q.color16;
      vclk_sel_o               <= vclk_sel;
    end
  end

  // ack only ever answers a pending request
  a_ack_after_req : assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
    $rose(cfg_ack_o) |-> $past(cfg_req_i)
  );

endmodule

// ==== hdl/ppu_pkg.sv ====
// shared widths, types and constants of the N64 video input PPU, imported by every RTL module
package ppu_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int COLOR_W_I  = 7;
  localparam int COLOR_W_O  = 8;
  localparam int SYNC_W     = 4;
  localparam int LINE_CNT_W = 10;

  // bit positions inside sync_t
  localparam int SYNC_NVSYNC_BIT = 3;
  localparam int SYNC_NHSYNC_BIT = 1;

  // field classification in lines per field
  localparam int PAL_LINE_THRESHOLD = 288;
  localparam int MIN_FIELD_LINES    = 200;

  typedef logic [COLOR_W_I-1:0]  color_i_t;
  typedef logic [COLOR_W_O-1:0]  color_o_t;
  // {nVSYNC, nCLAMP, nHSYNC, nCSYNC}, all active low
  typedef logic [SYNC_W-1:0]     sync_t;
  typedef logic [LINE_CNT_W-1:0] line_cnt_t;

  // ==================================================
  // configuration and video mode
  // ==================================================
  typedef enum logic [2:0] {
    RES_480P  = 3'd0,
    RES_720P  = 3'd1,
    RES_960P  = 3'd2,
    RES_1080P = 3'd3,
    RES_1200P = 3'd4,
    RES_1440P = 3'd5,
    RES_240P  = 3'd6
  } target_res_e;

  typedef struct packed {
    target_res_e target_res;
    logic        use_vga_480p;
    logic        force60;
    logic        force50;
    logic        low_latency;
    logic        color16;
  } ppu_cfg_t;

  typedef struct packed {
    target_res_e target_res;
    logic        is_50hz;
  } vmode_t;

  typedef struct packed {
    logic detected;
    logic pal;
    logic n64_480i;
  } vinfo_t;

  typedef struct packed {
    vinfo_t vinfo;
    vmode_t vmode;
    logic   llm;
    logic   color16;
  } ppu_state_t;

  typedef struct packed {
    sync_t    sync;
    color_o_t red;
    color_o_t green;
    color_o_t blue;
  } pixel_t;

  // ==================================================
  // state machines
  // ==================================================
  typedef enum logic [1:0] {PH_SYNC, PH_RED, PH_GREEN, PH_BLUE} demux_phase_e;

  typedef enum logic {HS_IDLE, HS_ACK} cfg_hs_e;

endpackage
